// ==== build.f ====
+incdir+include
design/bram_types_pkg.sv
design/ctrl_types_pkg.sv
design/sdpram.sv
design/n_delay.sv
design/stream_loader.sv
design/always_valid_cyclic_bram.sv
design/pass_tracker.sv
design/cyclic_bram_top.sv
testbench/cyclic_bram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cyclic weight store testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cyclic_bram_tb -f build.f \
  -o cyclic_bram_sim > compile.log 2>&1 \
  || { echo "Compile failed, see compile.log"; exit 1; }

./obj_dir/cyclic_bram_sim > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log \
  && { echo "Simulation finished cleanly"; exit 0; } \
  || { echo "Simulation ended without a result, see sim.log"; exit 1; }

// ==== testbench/cyclic_bram_tb.sv ====
// Testbench for the cyclic weight store with random load and replay checked against a queue model
`timescale 1ns/1ps
`include "cyclic_bram_settings.svh"

module cyclic_bram_tb;

  localparam int LEN_MIN_M1   = `CB_LATENCY + 1;            // Shortest sequence the core replays
  localparam int LEN_SPAN     = `CB_DEPTH - LEN_MIN_M1;     // Choices for length_m1
  localparam int WORD_LIMIT   = 200;                        // Cycles allowed per loaded word
  localparam int LOADED_LIMIT = 10;
  localparam int REPLAY_LIMIT = 2000;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        clken;
  logic                        load;
  bram_types_pkg::addr_t       length_m1;
  logic                        s_valid;
  bram_types_pkg::word_t       s_data;
  logic                        m_ready;
  logic                        m_valid;
  bram_types_pkg::word_t       m_data;
  logic                        m_last;
  ctrl_types_pkg::pass_count_t pass_count;
  logic                        loaded;

  logic [31:0]                 lfsr = 32'hecd9_3da3;    // Stimulus generator state
  bram_types_pkg::word_t       model_q [$];             // Words in load order
  bram_types_pkg::addr_t       len_m1;                  // Programmed last address
  int                          len;
  int                          writes_done = 0;         // Words the RAM has taken
  bram_types_pkg::addr_t       idx = '0;                // Model index of the word on m_data
  ctrl_types_pkg::pass_count_t passes = '0;             // Transfers seen with the last index
  logic                        started = 1'b0;          // Monitor on after the reset check
  logic                        filling = 1'b0;          // Load sequence is being driven
  logic                        full_rate = 1'b0;        // Ready and enable forced high
  logic                        have_prev = 1'b0;
  logic                        prev_clken;
  logic                        prev_m_valid;
  logic                        prev_m_last;
  logic                        prev_loaded;
  bram_types_pkg::word_t       prev_m_data;
  ctrl_types_pkg::pass_count_t prev_pass_count;

  cyclic_bram_top DUT (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .load       (load),
    .length_m1  (length_m1),
    .s_valid    (s_valid),
    .s_data     (s_data),
    .m_ready    (m_ready),
    .m_valid    (m_valid),
    .m_data     (m_data),
    .m_last     (m_last),
    .pass_count (pass_count),
    .loaded     (loaded)
  );

  initial begin
    forever #10 clk = ~clk; // 20 ns period
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Output monitor sampling mid-cycle while inputs and outputs are settled
  always @(negedge clk) begin
    if (started) begin
      if (have_prev && !prev_clken) begin // Disabled edge must leave outputs alone
        check_value("loaded (clken low)", 64'(loaded), 64'(prev_loaded));
        check_value("m_valid (clken low)", 64'(m_valid), 64'(prev_m_valid));
        check_value("m_data (clken low)", 64'(m_data), 64'(prev_m_data));
        check_value("m_last (clken low)", 64'(m_last), 64'(prev_m_last));
        check_value("pass_count (clken low)", 64'(pass_count), 64'(prev_pass_count));
      end
      check_value("loaded", 64'(loaded), 64'(writes_done == len)); // Only after the last word
      check_value("m_valid", 64'(m_valid), 64'(writes_done == len));
      check_value("m_last", 64'(m_last), 64'(idx == len_m1));
      check_value("pass_count", 64'(pass_count), 64'(passes));
      if (m_valid) begin
        check_value("m_data", 64'(m_data), 64'(model_q[idx]));
      end
      if (full_rate) begin
        check_value("xfer", 64'(m_valid && m_ready && clken), 64'd1); // No bubble allowed
      end
      if (filling && s_valid && clken) begin
        writes_done++; // Write lands on the coming edge
      end
      if (m_valid && m_ready && clken) begin
        if (idx == len_m1) begin
          idx    = '0;
          passes = passes + 1'b1;
        end else begin
          idx = idx + 1'b1;
        end
      end
      prev_clken      = clken;
      prev_m_valid    = m_valid;
      prev_m_data     = m_data;
      prev_m_last     = m_last;
      prev_loaded     = loaded;
      prev_pass_count = pass_count;
      have_prev       = 1'b1;
    end
  end

  // Load pulse followed by each word with random gaps and enable drops until taken
  task automatic load_sequence();
    int     tries;
    logic   gap;
    logic   ce;
    bram_types_pkg::word_t word;
    @(posedge clk);
    load      <= 1'b1;
    length_m1 <= len_m1;
    clken     <= 1'b1;
    filling    = 1'b1;
    @(posedge clk);
    load <= 1'b0;
    for (int i = 0; i < len; i++) begin
      word = bram_types_pkg::word_t'(take_bits(32));
      model_q.push_back(word);
      tries = 0;
      do begin
        @(posedge clk);
        gap = (take_bits(2) == 0);  // About one gap in four
        ce  = (take_bits(3) != 0);  // Enable low one cycle in eight
        clken   <= ce;
        s_valid <= !gap;
        s_data  <= word;
        tries++;
        if (tries > WORD_LIMIT) begin
          stop_with_failure($sformatf("Word %0d was never taken by the loader", i));
        end
      end while (gap || !ce);
    end
    @(posedge clk);
    s_valid <= 1'b0;
    clken   <= 1'b1;
    filling  = 1'b0;
  endtask

  task automatic wait_loaded();
    int tries;
    tries = 0;
    @(negedge clk);
    while (!loaded) begin
      tries++;
      if (tries > LOADED_LIMIT) begin
        stop_with_failure("The store did not report loaded after the last word");
      end
      @(negedge clk);
    end
    check_value("m_data", 64'(m_data), 64'(model_q[0])); // First word shown first
  endtask

  // Random ready and enable until the given number of further passes is seen
  task automatic replay_random(input int extra_passes);
    ctrl_types_pkg::pass_count_t target;
    int                          cycles;
    target = ctrl_types_pkg::pass_count_t'(int'(passes) + extra_passes);
    cycles = 0;
    while (passes != target) begin
      @(posedge clk);
      m_ready <= (take_bits(2) != 0);
      clken   <= (take_bits(3) != 0);
      cycles++;
      if (cycles > REPLAY_LIMIT) begin
        stop_with_failure("Replay did not complete the expected passes in time");
      end
    end
    @(posedge clk);
    m_ready <= 1'b0;
    clken   <= 1'b1;
  endtask

  task automatic run_full_rate(input int cycles);
    @(posedge clk);
    m_ready  <= 1'b1;
    clken    <= 1'b1;
    full_rate = 1'b1;
    repeat (cycles) @(posedge clk);
    full_rate = 1'b0;
    m_ready  <= 1'b0;
  endtask

  // Second load with another length and a burst of stray words that the DUT drops
  task automatic reload_ignored();
    @(posedge clk);
    load      <= 1'b1;
    length_m1 <= ~len_m1;
    clken     <= 1'b1;
    @(posedge clk);
    load <= 1'b0;
    repeat (8) begin
      @(posedge clk);
      s_valid <= (take_bits(1) != 0);
      s_data  <= bram_types_pkg::word_t'(take_bits(32));
      m_ready <= (take_bits(1) != 0);
    end
    @(posedge clk);
    s_valid <= 1'b0;
  endtask

  initial begin
    rst       = 1'b1;
    clken     = 1'b1;
    load      = 1'b0;
    length_m1 = '0;
    s_valid   = 1'b0;
    s_data    = '0;
    m_ready   = 1'b0;
    len_m1 = bram_types_pkg::addr_t'(LEN_MIN_M1 + int'(take_bits(8) % LEN_SPAN));
    len    = int'(len_m1) + 1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("m_valid", 64'(m_valid), 64'd0);
    check_value("loaded", 64'(loaded), 64'd0);
    check_value("m_last", 64'(m_last), 64'd0);
    check_value("pass_count", 64'(pass_count), 64'd0);
    @(posedge clk);
    started = 1'b1;
    load_sequence();
    wait_loaded();
    replay_random(3);
    run_full_rate(2 * len + 2);
    reload_ignored();
    replay_random(2);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== design/cyclic_bram_top.sv ====
// Cyclic weight store top: loader, always-valid replay core and pass tracker wired together
`timescale 1ns/1ps

module cyclic_bram_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clken,
  input  logic                        load,
  input  bram_types_pkg::addr_t       length_m1,
  input  logic                        s_valid,
  input  bram_types_pkg::word_t       s_data,
  input  logic                        m_ready,
  output logic                        m_valid,
  output bram_types_pkg::word_t       m_data,
  output logic                        m_last,
  output ctrl_types_pkg::pass_count_t pass_count,
  output logic                        loaded
);

  logic                  wr_en;
  bram_types_pkg::word_t wr_data;
  bram_types_pkg::addr_t wr_addr;
  logic                  wr_last;
  bram_types_pkg::addr_t addr_max_1; // Shared by core and tracker
  logic                  xfer;

  stream_loader u_loader (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .load       (load),
    .length_m1  (length_m1),
    .s_valid    (s_valid),
    .s_data     (s_data),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .wr_addr    (wr_addr),
    .wr_last    (wr_last),
    .addr_max_1 (addr_max_1),
    .loaded     (loaded)
  );

  always_valid_cyclic_bram u_core (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .wr_addr    (wr_addr),
    .wr_last    (wr_last),
    .addr_max_1 (addr_max_1),
    .m_ready    (m_ready),
    .m_valid    (m_valid),
    .m_data     (m_data),
    .xfer       (xfer)
  );

  pass_tracker u_tracker (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .xfer       (xfer),
    .addr_max_1 (addr_max_1),
    .m_last     (m_last),
    .pass_count (pass_count)
  );

endmodule

// ==== design/pass_tracker.sv ====
// Output side of the weight store: tracks word index in a pass, flags the last word, counts passes
`timescale 1ns/1ps

module pass_tracker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clken,
  input  logic                        xfer,       // Word taken this cycle
  input  bram_types_pkg::addr_t       addr_max_1, // Index of the last word
  output logic                        m_last,
  output ctrl_types_pkg::pass_count_t pass_count
);

  bram_types_pkg::addr_t idx;      // Index of the word on m_data
  bram_types_pkg::addr_t idx_next;

  assign idx_next = (idx == addr_max_1) ? '0 : idx + 1'b1; // Wraps into the next pass

  always_ff @(posedge clk) begin
    if (rst) begin
      idx        <= '0;
      m_last     <= 1'b0;
      pass_count <= '0;
    end else if (clken && xfer) begin
      idx    <= idx_next;
      m_last <= (idx_next == addr_max_1); // Flag tracks the word now shown
      if (m_last) begin
        pass_count <= pass_count + 1'b1; // Pass done, wraps on overflow
      end
    end
  end

endmodule

// ==== design/always_valid_cyclic_bram.sv ====
// Always-valid cyclic replay core: RAM, read address ring and prefetch buffer hiding read latency
`timescale 1ns/1ps
`include "cyclic_bram_settings.svh"

module always_valid_cyclic_bram (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clken,
  input  logic                  wr_en,
  input  bram_types_pkg::word_t wr_data,
  input  bram_types_pkg::addr_t wr_addr,
  input  logic                  wr_last,
  input  bram_types_pkg::addr_t addr_max_1, // Last address of the sequence
  input  logic                  m_ready,
  output logic                  m_valid,
  output bram_types_pkg::word_t m_data,
  output logic                  xfer        // Word taken this cycle
);

  localparam int BUF_DEPTH = `CB_LATENCY + 1; // Covers words in flight plus the one shown

  // Buffer slots run 0 .. BUF_DEPTH-1, RAM reads start right after them
  localparam bram_types_pkg::bptr_t BPTR_LAST     = bram_types_pkg::bptr_t'(BUF_DEPTH - 1);
  localparam bram_types_pkg::addr_t RD_ADDR_START = bram_types_pkg::addr_t'(BUF_DEPTH);

  ctrl_types_pkg::core_state_e state;

  bram_types_pkg::word_t buffer [BUF_DEPTH]; // Prefetch buffer
  bram_types_pkg::bptr_t w_ptr;              // Next slot to fill
  bram_types_pkg::bptr_t r_ptr;              // Slot shown on m_data
  bram_types_pkg::addr_t rd_addr;            // Next RAM read address
  bram_types_pkg::word_t rd_data;            // RAM output
  logic                  rd_valid;           // RAM output belongs to an issued read
  logic                  buf_we;
  bram_types_pkg::word_t buf_din;

  assign xfer = clken && m_valid && m_ready;

  // Fill takes the stream, work takes RAM returns
  assign buf_we  = (state == ctrl_types_pkg::CORE_FILL) ? wr_en : rd_valid;
  assign buf_din = (state == ctrl_types_pkg::CORE_FILL) ? wr_data : rd_data;

  assign m_data = buffer[r_ptr]; // Straight from the buffer, not registered

  // Core state, leaves fill once every slot has a word
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ctrl_types_pkg::CORE_FILL;
    end else if (clken && (state == ctrl_types_pkg::CORE_FILL) && wr_en
                 && (w_ptr == BPTR_LAST)) begin
      state <= ctrl_types_pkg::CORE_WORK;
    end
  end

  // Buffer contents
  always_ff @(posedge clk) begin
    if (clken && buf_we) begin
      buffer[w_ptr] <= buf_din;
    end
  end

  // Pointers and read address
  always_ff @(posedge clk) begin
    if (rst) begin
      w_ptr   <= '0;
      r_ptr   <= '0;
      rd_addr <= RD_ADDR_START; // First BUF_DEPTH words come from the stream
    end else if (clken) begin
      if (buf_we) begin
        w_ptr <= (w_ptr == BPTR_LAST) ? '0 : w_ptr + 1'b1; // Ring over slots
      end
      if (xfer) begin
        r_ptr   <= (r_ptr == BPTR_LAST) ? '0 : r_ptr + 1'b1;
        rd_addr <= (rd_addr == addr_max_1) ? '0 : rd_addr + 1'b1; // Wrap at last address
      end
    end
  end

  // Valid once the whole sequence is stored, then stays up
  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
    end else if (clken && wr_last) begin
      m_valid <= 1'b1;
    end
  end

  sdpram #(
    .WIDTH   (`CB_WIDTH),
    .DEPTH   (`CB_DEPTH),
    .LATENCY (`CB_LATENCY)
  ) u_ram (
    .clk   (clk),
    .clken (clken),
    .we    (wr_en),
    .waddr (wr_addr),
    .wdata (wr_data),
    .raddr (rd_addr), // One read per transfer
    .rdata (rd_data)
  );

  // Marks RAM returns, lands with the data CB_LATENCY clocks after the read
  n_delay #(
    .N     (`CB_LATENCY),
    .WIDTH (1)
  ) u_rd_valid (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .data_in  (xfer),
    .data_out (rd_valid)
  );

endmodule

// ==== design/stream_loader.sv ====
// Input side of the weight store: captures the length and turns the word stream into RAM writes
`timescale 1ns/1ps

module stream_loader (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clken,
  input  logic                  load,       // One-cycle load command
  input  bram_types_pkg::addr_t length_m1,  // Last address, sampled with load
  input  logic                  s_valid,
  input  bram_types_pkg::word_t s_data,
  output logic                  wr_en,
  output bram_types_pkg::word_t wr_data,
  output bram_types_pkg::addr_t wr_addr,
  output logic                  wr_last,    // Final write of the sequence
  output bram_types_pkg::addr_t addr_max_1, // Held from the load onward
  output logic                  loaded
);

  ctrl_types_pkg::loader_state_e state;

  // Every valid word during fill is a write, no back-pressure
  assign wr_en   = clken && s_valid && (state == ctrl_types_pkg::LD_FILL);
  assign wr_data = s_data;
  assign wr_last = wr_en && (wr_addr == addr_max_1); // Write of the last address

  assign loaded = (state == ctrl_types_pkg::LD_FULL); // High the cycle after wr_last

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ctrl_types_pkg::LD_IDLE;
      wr_addr    <= '0;
      addr_max_1 <= '0;
    end else if (clken) begin
      case (state)
        ctrl_types_pkg::LD_IDLE: begin
          if (load) begin
            addr_max_1 <= length_m1; // Length captured once
            wr_addr    <= '0;        // Fill starts at address 0
            state      <= ctrl_types_pkg::LD_FILL;
          end
        end
        ctrl_types_pkg::LD_FILL: begin
          if (wr_en) begin
            wr_addr <= wr_addr + 1'b1; // Next address
            if (wr_last) begin
              state <= ctrl_types_pkg::LD_FULL;
            end
          end
        end
        default: begin
          // LD_FULL holds until reset, later loads are dropped
          state <= ctrl_types_pkg::LD_FULL;
        end
      endcase
    end
  end

endmodule

// ==== design/n_delay.sv ====
// Enabled N-stage shift line for a WIDTH-bit signal, cleared by synchronous reset
`timescale 1ns/1ps

module n_delay #(
  parameter int N     = 3,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clken,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] stage [N]; // One entry per clock of delay

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < N; i++) begin
        stage[i] <= '0; // Nothing in flight after reset
      end
    end else if (clken) begin
      stage[0] <= data_in;
      for (int i = 1; i < N; i++) begin
        stage[i] <= stage[i-1]; // Several entries may be set at once
      end
    end
  end

  assign data_out = stage[N-1];

endmodule

// ==== design/sdpram.sv ====
// Behavioral simple dual-port RAM with a registered read pipeline of LATENCY stages
`timescale 1ns/1ps

module sdpram #(
  parameter int WIDTH   = 32,
  parameter int DEPTH   = 16,
  parameter int LATENCY = 3
) (
  input  logic                     clk,
  input  logic                     clken, // Freezes both ports
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic [WIDTH-1:0]         wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output logic [WIDTH-1:0]         rdata
);

  logic [WIDTH-1:0] mem     [DEPTH];   // Word array
  logic [WIDTH-1:0] rd_pipe [LATENCY]; // Read pipeline, stage 0 is the array read

  // Write port
  always_ff @(posedge clk) begin
    if (clken && we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, LATENCY enabled stages from raddr to rdata
  always_ff @(posedge clk) begin
    if (clken) begin
      rd_pipe[0] <= mem[raddr]; // Array read register
      for (int i = 1; i < LATENCY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1]; // Output register chain
      end
    end
  end

  assign rdata = rd_pipe[LATENCY-1]; // Last stage drives the port

endmodule

// ==== design/ctrl_types_pkg.sv ====
// Control types of the cyclic weight store: loader and core states, pass count
`include "cyclic_bram_settings.svh"

package ctrl_types_pkg;

  // Input side states
  typedef enum logic [1:0] {
    LD_IDLE = 2'd0, // Waiting for a load command
    LD_FILL = 2'd1, // Accepting words into the RAM
    LD_FULL = 2'd2  // RAM holds the full sequence
  } loader_state_e;

  // Source of prefetch buffer writes
  typedef enum logic {
    CORE_FILL = 1'b0, // Buffer takes incoming words
    CORE_WORK = 1'b1  // Buffer takes RAM read data
  } core_state_e;

  // Completed passes
  typedef logic [`CB_PASS_BITS-1:0] pass_count_t;

endpackage

// ==== design/bram_types_pkg.sv ====
// Storage types of the cyclic weight store: data word, RAM address, prefetch pointer
`include "cyclic_bram_settings.svh"

package bram_types_pkg;

  // One stored weight word
  typedef logic [`CB_WIDTH-1:0] word_t;

  // RAM address, also used for the programmed last address
  typedef logic [$clog2(`CB_DEPTH)-1:0] addr_t;

  // Slot index into the prefetch buffer of CB_LATENCY + 1 words
  typedef logic [$clog2(`CB_LATENCY+1)-1:0] bptr_t;

endpackage

// ==== include/cyclic_bram_settings.svh ====
// Cyclic weight store settings: word width, RAM depth, read latency, pass counter width
`ifndef CYCLIC_BRAM_SETTINGS_SVH
`define CYCLIC_BRAM_SETTINGS_SVH

// Bits per stored data word
`define CB_WIDTH 32

// Number of RAM words, must exceed CB_LATENCY + 1
`define CB_DEPTH 16

// RAM read latency in enabled clocks
`define CB_LATENCY 3

// Completed pass counter width, wraps on overflow
`define CB_PASS_BITS 8

`endif
